/* logic/a23_trace_defs.svh */
`ifndef A23_TRACE_DEFS_SVH
`define A23_TRACE_DEFS_SVH

// core bus address width.
`define A23_ADDR_W 32

// data and instruction word width.
`define A23_DATA_W 32

// one byte enable per byte lane of the data word.
`define A23_BE_W 4

// width of the free-running trace timestamp.
`define TRACE_TS_W 16

// record queue depth in the merge block.
// must be a power of two no smaller than 2.
`define TRACE_FIFO_DEPTH 8

`endif

/* logic/a23_trace_pkg.sv */
`include "a23_trace_defs.svh"

package a23_trace_pkg;

	// kind of event carried by a trace record.
	typedef enum logic [2:0] {
		TK_INSN  = 3'd0,
		TK_UNDEF = 3'd1,
		TK_IRQ   = 3'd2,
		TK_LOAD  = 3'd3,
		TK_STORE = 3'd4
	} trace_kind_e;

	// one retired, undefined or interrupted instruction.
	typedef struct packed {
		logic                   valid;
		trace_kind_e            kind;
		logic [`A23_ADDR_W-1:0] addr;
		logic [`A23_DATA_W-1:0] insn;
	} insn_event_t;

	// one load or store on the core data bus.
	// data already has disabled lanes cleared.
	typedef struct packed {
		logic                   valid;
		trace_kind_e            kind;
		logic [`A23_ADDR_W-1:0] addr;
		logic [`A23_BE_W-1:0]   be;
		logic [`A23_DATA_W-1:0] data;
	} data_event_t;

	// trace record as queued and emitted by the merge block.
	// instruction records carry all-ones enables and the instruction word as data.
	typedef struct packed {
		trace_kind_e            kind;
		logic [`TRACE_TS_W-1:0] ts;
		logic [`A23_ADDR_W-1:0] addr;
		logic [`A23_BE_W-1:0]   be;
		logic [`A23_DATA_W-1:0] data;
	} trace_rec_t;

endpackage

/* logic/insn_trace_capture.sv */
`timescale 1ns/1ps
`include "a23_trace_defs.svh"

module insn_trace_capture (
	input  logic                        clk,
	input  logic                        i_rst,
	input  logic                        i_fetch_stall,
	input  logic                        i_instruction_valid,
	input  logic                        i_instruction_execute,
	input  logic                        i_instruction_undefined,
	input  logic                        i_interrupt,
	input  logic [`A23_ADDR_W-1:0]      i_instruction_address,
	input  logic [`A23_DATA_W-1:0]      i_instruction,
	output a23_trace_pkg::insn_event_t  o_event
);

	// qualified retirement in the current cycle.
	logic                       retire;
	// event kind decoded from the probe.
	a23_trace_pkg::trace_kind_e kind;

	// registered event fields.
	logic                       ev_valid;
	a23_trace_pkg::trace_kind_e ev_kind;
	logic [`A23_ADDR_W-1:0]     ev_addr;
	logic [`A23_DATA_W-1:0]     ev_insn;

	// an instruction counts only when the pipeline moves.
	// interrupt entry counts even when the instruction does not execute.
	assign retire = !i_fetch_stall && i_instruction_valid &&
		(i_interrupt || i_instruction_execute);

	// kind priority is irq over undefined over a plain instruction.
	always_comb begin
		if (i_interrupt) begin
			kind = a23_trace_pkg::TK_IRQ;
		end else if (i_instruction_undefined) begin
			kind = a23_trace_pkg::TK_UNDEF;
		end else begin
			kind = a23_trace_pkg::TK_INSN;
		end
	end

	// one-cycle valid pulse per retirement.
	always_ff @(posedge clk) begin
		if (i_rst) begin
			ev_valid <= 1'b0;
		end else begin
			ev_valid <= retire;
		end
	end

	// payload only loads on a retirement.
	// it holds its old value otherwise.
	always_ff @(posedge clk) begin
		if (retire) begin
			ev_kind <= kind;
			ev_addr <= i_instruction_address;
			ev_insn <= i_instruction;
		end
	end

	assign o_event = '{
		valid: ev_valid,
		kind:  ev_kind,
		addr:  ev_addr,
		insn:  ev_insn
	};

	// the merge block reads valid every cycle.
	// an unknown here would corrupt its fifo count.
	a_valid_known: assert property (
		@(posedge clk) disable iff (i_rst)
		!$isunknown(o_event.valid)
	) else $error("insn_trace_capture: event valid is unknown");

endmodule

/* logic/data_trace_capture.sv */
`timescale 1ns/1ps
`include "a23_trace_defs.svh"

module data_trace_capture (
	input  logic                        clk,
	input  logic                        i_rst,
	input  logic                        i_fetch_stall,
	input  logic                        i_data_access,
	input  logic                        i_write_enable,
	input  logic [`A23_ADDR_W-1:0]      i_address,
	input  logic [`A23_BE_W-1:0]        i_byte_enable,
	input  logic [`A23_DATA_W-1:0]      i_write_data,
	input  logic [`A23_DATA_W-1:0]      i_read_data,
	output a23_trace_pkg::data_event_t  o_event
);

	// qualified bus access in the current cycle.
	logic                       access;
	// load or store.
	a23_trace_pkg::trace_kind_e kind;
	// data before and after lane masking.
	logic [`A23_DATA_W-1:0]     raw_data;
	logic [`A23_DATA_W-1:0]     lane_data;

	// registered event fields.
	logic                       ev_valid;
	a23_trace_pkg::trace_kind_e ev_kind;
	logic [`A23_ADDR_W-1:0]     ev_addr;
	logic [`A23_BE_W-1:0]       ev_be;
	logic [`A23_DATA_W-1:0]     ev_data;

	// a stalled cycle repeats the same access.
	// only the unstalled cycle is traced.
	assign access = !i_fetch_stall && i_data_access;

	assign kind = i_write_enable ? a23_trace_pkg::TK_STORE : a23_trace_pkg::TK_LOAD;

	// stores show what the core drives.
	// loads show what memory returns.
	assign raw_data = i_write_enable ? i_write_data : i_read_data;

	// bytes outside the enabled lanes are undefined on the bus.
	// clear them so records compare cleanly.
	always_comb begin
		for (int b = 0; b < `A23_BE_W; b++) begin
			lane_data[b*8 +: 8] = i_byte_enable[b] ? raw_data[b*8 +: 8] : 8'h00;
		end
	end

	// one-cycle valid pulse per access.
	always_ff @(posedge clk) begin
		if (i_rst) begin
			ev_valid <= 1'b0;
		end else begin
			ev_valid <= access;
		end
	end

	// payload loads only on an access.
	always_ff @(posedge clk) begin
		if (access) begin
			ev_kind <= kind;
			ev_addr <= i_address;
			ev_be   <= i_byte_enable;
			ev_data <= lane_data;
		end
	end

	assign o_event = '{
		valid: ev_valid,
		kind:  ev_kind,
		addr:  ev_addr,
		be:    ev_be,
		data:  ev_data
	};

	// the core never issues a bus cycle without at least one lane.
	// a zero mask would give a record with no data at all.
	a_be_nonzero: assert property (
		@(posedge clk) disable iff (i_rst)
		access |-> (i_byte_enable != '0)
	) else $error("data_trace_capture: access with no byte enables");

endmodule

/* logic/trace_merge.sv */
`timescale 1ns/1ps
`include "a23_trace_defs.svh"

module trace_merge (
	input  logic                        clk,
	input  logic                        i_rst,
	input  a23_trace_pkg::insn_event_t  i_insn_event,
	input  a23_trace_pkg::data_event_t  i_data_event,
	output a23_trace_pkg::trace_rec_t   o_rec,
	output logic                        o_rec_valid,
	output logic                        o_overflow
);

	localparam int DEPTH = `TRACE_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);
	// depth at the width of the free-slot arithmetic.
	localparam logic [CNT_W:0] DEPTH_W = (CNT_W + 1)'(DEPTH);

	// free-running timestamp.
	logic [`TRACE_TS_W-1:0]    ts_q;

	// record storage.
	a23_trace_pkg::trace_rec_t mem [DEPTH];
	logic [PTR_W-1:0]          wr_ptr;
	logic [PTR_W-1:0]          rd_ptr;
	logic [CNT_W-1:0]          cnt;

	// per-cycle fifo control.
	logic                      pop;
	logic [CNT_W:0]            free_slots;
	logic                      push_insn;
	logic                      push_data;
	logic                      drop;
	logic [PTR_W-1:0]          data_ptr;

	// records built from the incoming events.
	a23_trace_pkg::trace_rec_t insn_rec;
	a23_trace_pkg::trace_rec_t data_rec;

	// zero in the first cycle after reset.
	// wraps at the full width.
	always_ff @(posedge clk) begin
		if (i_rst) begin
			ts_q <= '0;
		end else begin
			ts_q <= ts_q + 1'b1;
		end
	end

	// both records take the stamp of the cycle the events are present.
	// instruction words travel in the data field with every lane enabled.
	assign insn_rec = '{
		kind: i_insn_event.kind,
		ts:   ts_q,
		addr: i_insn_event.addr,
		be:   '1,
		data: i_insn_event.insn
	};

	assign data_rec = '{
		kind: i_data_event.kind,
		ts:   ts_q,
		addr: i_data_event.addr,
		be:   i_data_event.be,
		data: i_data_event.data
	};

	// one record leaves every cycle the fifo holds anything.
	assign pop = (cnt != '0);

	// the slot freed by this cycle's pop is usable by this cycle's push.
	assign free_slots = DEPTH_W - {1'b0, cnt} + {{CNT_W{1'b0}}, pop};

	// instruction record claims the first free slot.
	assign push_insn = i_insn_event.valid && (free_slots != '0);

	// data needs one more slot when the instruction also went in.
	assign push_data = i_data_event.valid &&
		(free_slots > {{CNT_W{1'b0}}, push_insn});

	// any refused event is lost for good.
	assign drop = (i_insn_event.valid && !push_insn) ||
		(i_data_event.valid && !push_data);

	// data lands right after the instruction when both are written.
	assign data_ptr = wr_ptr + PTR_W'(push_insn);

	// pointers wrap naturally since depth is a power of two.
	always_ff @(posedge clk) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt    <= '0;
		end else begin
			wr_ptr <= wr_ptr + PTR_W'(push_insn) + PTR_W'(push_data);
			rd_ptr <= rd_ptr + PTR_W'(pop);
			cnt    <= cnt + CNT_W'(push_insn) + CNT_W'(push_data) - CNT_W'(pop);
		end
	end

	// storage writes.
	// two write ports so both streams can land in one cycle.
	always_ff @(posedge clk) begin
		if (push_insn) begin
			mem[wr_ptr] <= insn_rec;
		end
		if (push_data) begin
			mem[data_ptr] <= data_rec;
		end
	end

	// output register.
	always_ff @(posedge clk) begin
		if (pop) begin
			o_rec <= mem[rd_ptr];
		end
	end

	// valid strobe and sticky overflow.
	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_rec_valid <= 1'b0;
			o_overflow  <= 1'b0;
		end else begin
			o_rec_valid <= pop;
			o_overflow  <= o_overflow | drop;
		end
	end

	// push and pop accounting must keep the count in range.
	a_cnt_bound: assert property (
		@(posedge clk) disable iff (i_rst)
		cnt <= DEPTH_W[CNT_W-1:0] || cnt == DEPTH_W
	) else $error("trace_merge: fifo count above depth");

	// a strobe must come from a slot the pointers show as filled.
	a_no_empty_pop: assert property (
		@(posedge clk) disable iff (i_rst)
		o_rec_valid |-> $past(wr_ptr != rd_ptr || cnt == DEPTH_W[CNT_W-1:0])
	) else $error("trace_merge: record emitted from an empty fifo");

endmodule

/* logic/a23_trace_monitor.sv */
`timescale 1ns/1ps
`include "a23_trace_defs.svh"

module a23_trace_monitor (
	input  logic                       clk,
	input  logic                       i_rst,
	// instruction probe.
	input  logic                       i_fetch_stall,
	input  logic                       i_instruction_valid,
	input  logic                       i_instruction_execute,
	input  logic                       i_instruction_undefined,
	input  logic                       i_interrupt,
	input  logic [`A23_ADDR_W-1:0]     i_instruction_address,
	input  logic [`A23_DATA_W-1:0]     i_instruction,
	// data probe.
	input  logic                       i_data_access,
	input  logic                       i_write_enable,
	input  logic [`A23_ADDR_W-1:0]     i_address,
	input  logic [`A23_BE_W-1:0]       i_byte_enable,
	input  logic [`A23_DATA_W-1:0]     i_write_data,
	input  logic [`A23_DATA_W-1:0]     i_read_data,
	// trace output.
	output a23_trace_pkg::trace_rec_t  o_rec,
	output logic                       o_rec_valid,
	output logic                       o_overflow
);

	// event streams from the capture blocks.
	a23_trace_pkg::insn_event_t insn_event;
	a23_trace_pkg::data_event_t data_event;

	// the stall signal feeds both capture blocks.
	insn_trace_capture u_insn (
		.clk                     (clk),
		.i_rst                   (i_rst),
		.i_fetch_stall           (i_fetch_stall),
		.i_instruction_valid     (i_instruction_valid),
		.i_instruction_execute   (i_instruction_execute),
		.i_instruction_undefined (i_instruction_undefined),
		.i_interrupt             (i_interrupt),
		.i_instruction_address   (i_instruction_address),
		.i_instruction           (i_instruction),
		.o_event                 (insn_event)
	);

	data_trace_capture u_data (
		.clk            (clk),
		.i_rst          (i_rst),
		.i_fetch_stall  (i_fetch_stall),
		.i_data_access  (i_data_access),
		.i_write_enable (i_write_enable),
		.i_address      (i_address),
		.i_byte_enable  (i_byte_enable),
		.i_write_data   (i_write_data),
		.i_read_data    (i_read_data),
		.o_event        (data_event)
	);

	// stamps, orders and queues both streams.
	trace_merge u_merge (
		.clk          (clk),
		.i_rst        (i_rst),
		.i_insn_event (insn_event),
		.i_data_event (data_event),
		.o_rec        (o_rec),
		.o_rec_valid  (o_rec_valid),
		.o_overflow   (o_overflow)
	);

endmodule

/* sim/a23_trace_monitor_tb.sv */
`timescale 1ns/1ps
`include "a23_trace_defs.svh"

module a23_trace_monitor_tb;

	localparam int DEPTH      = `TRACE_FIFO_DEPTH;
	localparam int RST_CYCLES = 3;
	localparam int N_RETIRE   = 5;
	localparam int N_SUPPRESS = 6;
	localparam int N_LDST     = 16;
	localparam int N_PAIR     = 5;
	localparam int N_RANDOM   = 400;
	localparam int N_FLOOD    = 20;
	// each of the six tests ends with a drain of at most this many cycles.
	localparam int DRAIN_MAX  = DEPTH + 6;
	localparam int STIM_CYCLES = RST_CYCLES + N_RETIRE + N_SUPPRESS + N_LDST + N_PAIR +
		N_RANDOM + N_FLOOD + 6 * DRAIN_MAX;
	localparam int TIMEOUT    = STIM_CYCLES + DEPTH * 4;

	// one cycle of both probes.
	typedef struct packed {
		logic                   stall;
		logic                   ivalid;
		logic                   exec;
		logic                   undef;
		logic                   irq;
		logic [`A23_ADDR_W-1:0] iaddr;
		logic [`A23_DATA_W-1:0] insn;
		logic                   dacc;
		logic                   we;
		logic [`A23_ADDR_W-1:0] daddr;
		logic [`A23_BE_W-1:0]   be;
		logic [`A23_DATA_W-1:0] wdata;
		logic [`A23_DATA_W-1:0] rdata;
	} probe_t;

	logic                      clk;
	logic                      i_rst;
	probe_t                    probe;
	a23_trace_pkg::trace_rec_t o_rec;
	logic                      o_rec_valid;
	logic                      o_overflow;

	// records the DUT must emit, oldest first.
	a23_trace_pkg::trace_rec_t expected_q[$];
	logic [31:0]               lcg_state = 32'h2b04;
	int                        cycle = 0;
	int                        watchdog = 0;
	// occupancy of the modelled record fifo.
	int                        model_cnt = 0;
	logic                      ovf_expected = 1'b0;
	logic                      ovf_seen = 1'b0;
	string                     test_name = "reset";

	a23_trace_monitor uut (
		.clk                     (clk),
		.i_rst                   (i_rst),
		.i_fetch_stall           (probe.stall),
		.i_instruction_valid     (probe.ivalid),
		.i_instruction_execute   (probe.exec),
		.i_instruction_undefined (probe.undef),
		.i_interrupt             (probe.irq),
		.i_instruction_address   (probe.iaddr),
		.i_instruction           (probe.insn),
		.i_data_access           (probe.dacc),
		.i_write_enable          (probe.we),
		.i_address               (probe.daddr),
		.i_byte_enable           (probe.be),
		.i_write_data            (probe.wdata),
		.i_read_data             (probe.rdata),
		.o_rec                   (o_rec),
		.o_rec_valid             (o_rec_valid),
		.o_overflow              (o_overflow)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// zero in the first cycle after reset, like the trace timestamp.
	always @(posedge clk) begin
		if (i_rst) begin
			cycle <= 0;
		end else begin
			cycle <= cycle + 1;
		end
	end

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation aborted");
	endtask

	task automatic check_value(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			fail_now($sformatf("FAILED %s %s: expected %0h, actual %0h",
				test_name, what, expected, actual));
		end
	endtask

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// control bits as given, payload from the lcg.
	function automatic probe_t make_probe(input logic stall, ivalid, exec, undef, irq,
		dacc, we);
		probe_t      p;
		logic [31:0] r;
		r = next_rand();
		p = '{stall: stall, ivalid: ivalid, exec: exec, undef: undef, irq: irq,
			iaddr: {r[31:2], 2'b00}, insn: next_rand(), dacc: dacc, we: we,
			daddr: next_rand(), be: r[3:0], wdata: next_rand(), rdata: next_rand()};
		// the core always enables at least one lane.
		if (p.be == '0) begin
			p.be = 4'b0001;
		end
		return p;
	endfunction

	// expected record for a qualified instruction.
	function automatic a23_trace_pkg::trace_rec_t ref_insn_rec(input probe_t p,
		input logic [`TRACE_TS_W-1:0] ts);
		a23_trace_pkg::trace_rec_t r;
		if (p.irq) begin
			r.kind = a23_trace_pkg::TK_IRQ;
		end else if (p.undef) begin
			r.kind = a23_trace_pkg::TK_UNDEF;
		end else begin
			r.kind = a23_trace_pkg::TK_INSN;
		end
		r.ts   = ts;
		r.addr = p.iaddr;
		r.be   = '1;
		r.data = p.insn;
		return r;
	endfunction

	// expected record for a qualified bus access.
	function automatic a23_trace_pkg::trace_rec_t ref_data_rec(input probe_t p,
		input logic [`TRACE_TS_W-1:0] ts);
		a23_trace_pkg::trace_rec_t r;
		logic [`A23_DATA_W-1:0]    src;
		src    = p.we ? p.wdata : p.rdata;
		r.kind = p.we ? a23_trace_pkg::TK_STORE : a23_trace_pkg::TK_LOAD;
		r.ts   = ts;
		r.addr = p.daddr;
		r.be   = p.be;
		for (int b = 0; b < `A23_BE_W; b++) begin
			r.data[b*8 +: 8] = p.be[b] ? src[b*8 +: 8] : 8'h00;
		end
		return r;
	endfunction

	// one merge cycle.
	// a pop frees its slot for this cycle's pushes, and the instruction goes first.
	task automatic model_step(input probe_t p, input logic [`TRACE_TS_W-1:0] ts);
		logic insn_ev;
		logic data_ev;
		logic pop;
		int   free_slots;
		logic take_insn;
		logic take_data;
		insn_ev    = !p.stall && p.ivalid && (p.irq || p.exec);
		data_ev    = !p.stall && p.dacc;
		pop        = (model_cnt != 0);
		free_slots = DEPTH - model_cnt + int'(pop);
		take_insn  = insn_ev && (free_slots > 0);
		take_data  = data_ev && (free_slots > int'(take_insn));
		if (take_insn) begin
			expected_q.push_back(ref_insn_rec(p, ts));
		end
		if (take_data) begin
			expected_q.push_back(ref_data_rec(p, ts));
		end
		if ((insn_ev && !take_insn) || (data_ev && !take_data)) begin
			ovf_expected = 1'b1;
		end
		model_cnt = model_cnt + int'(take_insn) + int'(take_data) - int'(pop);
	endtask

	// probe sampled at the next edge is stamped one cycle later.
	task automatic drive_cycle(input probe_t p);
		logic [`TRACE_TS_W-1:0] ts;
		ts    = cycle + 1;
		probe = p;
		model_step(p, ts);
		@(posedge clk);
		#1;
	endtask

	// idle until every expected record is out, then cover the pipeline.
	task automatic drain();
		while (expected_q.size() != 0) begin
			drive_cycle(make_probe(0, 0, 0, 0, 0, 0, 0));
		end
		repeat (3) drive_cycle(make_probe(0, 0, 0, 0, 0, 0, 0));
	endtask

	always @(posedge clk) begin
		watchdog <= watchdog + 1;
		if (watchdog >= TIMEOUT) begin
			fail_now("timeout: run did not finish within the cycle limit");
		end
	end

	// outputs settle well before the falling edge.
	always @(negedge clk) begin : check_records
		a23_trace_pkg::trace_rec_t exp_rec;
		if (!i_rst) begin
			if (o_rec_valid) begin
				if (expected_q.size() == 0) begin
					fail_now("trace record emitted while none was expected");
				end else begin
					exp_rec = expected_q.pop_front();
					check_value("kind", exp_rec.kind, o_rec.kind);
					check_value("timestamp", exp_rec.ts, o_rec.ts);
					check_value("address", exp_rec.addr, o_rec.addr);
					check_value("byte enables", exp_rec.be, o_rec.be);
					check_value("data", exp_rec.data, o_rec.data);
				end
			end
			if (o_overflow && !ovf_expected) begin
				fail_now("overflow flag rose while no event was dropped");
			end
			if (ovf_seen && !o_overflow) begin
				fail_now("overflow flag cleared without a reset");
			end
			ovf_seen = o_overflow;
		end
	end

	initial begin
		logic [31:0] r;
		probe = '0;
		i_rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		i_rst = 1'b0;
		// plain, undefined, interrupt, interrupt over undefined, plain.
		test_name = "retire";
		drive_cycle(make_probe(0, 1, 1, 0, 0, 0, 0));
		drive_cycle(make_probe(0, 1, 1, 1, 0, 0, 0));
		drive_cycle(make_probe(0, 1, 0, 0, 1, 0, 0));
		drive_cycle(make_probe(0, 1, 1, 1, 1, 0, 0));
		drive_cycle(make_probe(0, 1, 1, 0, 0, 0, 0));
		drain();
		// stalled, invalid, not executed, stalled access, no access, all stalled.
		test_name = "suppress";
		drive_cycle(make_probe(1, 1, 1, 0, 1, 1, 1));
		drive_cycle(make_probe(0, 0, 1, 0, 1, 0, 0));
		drive_cycle(make_probe(0, 1, 0, 1, 0, 0, 0));
		drive_cycle(make_probe(1, 0, 0, 0, 0, 1, 0));
		drive_cycle(make_probe(0, 0, 0, 0, 0, 0, 1));
		drive_cycle(make_probe(1, 1, 1, 1, 0, 1, 0));
		drain();
		test_name = "load_store";
		for (int i = 0; i < N_LDST; i++) begin
			drive_cycle(make_probe(0, 0, 0, 0, 0, 1, next_rand() > 32'h7fff_ffff));
		end
		drain();
		test_name = "same_cycle";
		for (int i = 0; i < N_PAIR; i++) begin
			drive_cycle(make_probe(0, 1, 1, 0, 0, 1, i[0]));
		end
		drain();
		// about one event every two cycles keeps the fifo far from full.
		test_name = "random";
		for (int i = 0; i < N_RANDOM; i++) begin
			r = next_rand();
			drive_cycle(make_probe(r[31:29] == 0, r[3], r[5:4] != 0, r[9:6] == 0,
				r[13:10] == 0, r[16:14] == 0, r[17]));
		end
		drain();
		check_value("overflow", 0, o_overflow);
		test_name = "overflow";
		for (int i = 0; i < N_FLOOD; i++) begin
			drive_cycle(make_probe(0, 1, 1, 0, 0, 1, i[0]));
		end
		drain();
		check_value("overflow", 1, o_overflow);
		if (expected_q.size() != 0) begin
			fail_now("expected records still queued at end of run");
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

/* a23_trace_monitor.f */
+incdir+logic
logic/a23_trace_pkg.sv
logic/insn_trace_capture.sv
logic/data_trace_capture.sv
logic/trace_merge.sv
logic/a23_trace_monitor.sv
sim/a23_trace_monitor_tb.sv

/* Bender.yml */
package:
  name: a23_trace_monitor

export_include_dirs:
  - logic

sources:
  - logic/a23_trace_pkg.sv
  - logic/insn_trace_capture.sv
  - logic/data_trace_capture.sv
  - logic/trace_merge.sv
  - logic/a23_trace_monitor.sv
  - target: test
    files:
      - sim/a23_trace_monitor_tb.sv
